/* verification/sdCmd_stim.txt */
# index argument config behavior busyCycles payload expStatus expCardErr, all hex
# behavior 0 good, 1 bad CRC, 2 wrong index, 3 silent, 4 busy for busyCycles
0D 12340000 19 0 00 00000900 01 0
11 00001000 39 0 00 00000900 01 0
18 00002000 59 0 00 00000900 01 0
07 12340000 1D 4 14 00000700 01 0
02 00000000 0A 0 00 1D4144534430302010A1B2C3D40141 01 0
09 12340000 0A 0 00 400E00325B59000076B27F800A4040 01 0
0D 12340000 39 1 00 00000900 0A 0
0D 12340000 11 1 00 00000900 01 0
0D 12340000 19 2 00 00000900 12 0
0D 12340000 09 2 00 00000900 01 0
0D 12340000 19 3 00 00000000 06 0
00 00000000 00 3 00 00000000 01 0
0D 12340000 19 0 00 80000000 01 1
0D 12340000 19 1 00 80000000 0A 0
37 00000000 19 0 00 00000120 01 0

/* sdCmdCtrl.f */
+incdir+hdl
hdl/sdHostPkg.sv
hdl/sdLinePkg.sv
hdl/sdCrc7.sv
hdl/sdCmdPath.sv
hdl/sdCmdFront.sv
hdl/sdCmdCtrl.sv
verification/tbClock.sv
verification/sdCardModel.sv
verification/sdCmdCtrlTb.sv

/* Makefile */
BUILD_DIR = build

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sdCmdCtrl.f \
		--top-module sdCmdCtrlTb -Mdir $(BUILD_DIR) -o simv
	@out=$$(./$(BUILD_DIR)/simv 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf $(BUILD_DIR)

/* verification/sdCmdCtrlTb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "sdCmd_settings.svh"

module sdCmdCtrlTb
	import sdHostPkg::*;
();

	localparam int MAX_LINES = 64;
	localparam int RESET_CYCLES = 8;
	localparam int CYCLES_PER_LINE = 2000;
	localparam logic [3:0] WRONG_INDEX = 4'd2;
	localparam logic [3:0] SILENT = 4'd3;

	logic clk;
	logic rst;
	logic reqValid;
	logic [5:0] reqIndex;
	logic [31:0] reqArgument;
	cmdConfigT reqConfig;
	logic reqReady;
	logic resValid;
	cmdStatusT resStatus;
	respWordT resResponse;
	logic resCardErr;
	logic resReady = 1'b0;
	logic [`CMD_TIMEOUT_W-1:0] timeoutValue;
	logic cmdIn;
	logic sdBusy;
	logic cmdOut;
	logic cmdOe;
	logic startRx;
	logic startTx;

	// Card model controls and observations
	logic [3:0] cardBehavior;
	logic [15:0] cardBusy;
	logic [1:0] cardKind;
	logic [119:0] cardPayload;
	logic [5:0] cardIndex;
	logic [31:0] cardArgument;
	logic [6:0] cardRxCrc;
	logic [6:0] cardCalcCrc;
	logic [2:0] cardFrameBits;
	logic [15:0] cardFrames;

	logic [5:0] stimIndex [MAX_LINES];
	logic [31:0] stimArgument [MAX_LINES];
	logic [6:0] stimConfig [MAX_LINES];
	logic [3:0] stimBehavior [MAX_LINES];
	logic [15:0] stimBusy [MAX_LINES];
	logic [119:0] stimPayload [MAX_LINES];
	logic [4:0] stimStatus [MAX_LINES];
	logic stimCardErr [MAX_LINES];
	int stimCount = 0;

	int rxPulses = 0;
	int txPulses = 0;
	logic heldValid = 1'b0;
	cmdStatusT heldStatus;
	respWordT heldResponse;
	logic heldCardErr;

	tbClock #(.PERIOD(8)) clock (.clk(clk));

	sdCmdCtrl dut (
		.clk(clk),
		.rst(rst),
		.reqValid(reqValid),
		.reqIndex(reqIndex),
		.reqArgument(reqArgument),
		.reqConfig(reqConfig),
		.reqReady(reqReady),
		.resValid(resValid),
		.resStatus(resStatus),
		.resResponse(resResponse),
		.resCardErr(resCardErr),
		.resReady(resReady),
		.timeoutValue(timeoutValue),
		.cmdIn(cmdIn),
		.sdBusy(sdBusy),
		.cmdOut(cmdOut),
		.cmdOe(cmdOe),
		.startRx(startRx),
		.startTx(startTx)
	);

	sdCardModel card (
		.clk(clk),
		.cmdOut(cmdOut),
		.cmdOe(cmdOe),
		.behavior(cardBehavior),
		.busyCycles(cardBusy),
		.respKind(cardKind),
		.payload(cardPayload),
		.cmdIn(cmdIn),
		.sdBusy(sdBusy),
		.rxIndex(cardIndex),
		.rxArgument(cardArgument),
		.rxCrc(cardRxCrc),
		.calcCrc(cardCalcCrc),
		.rxFrameBits(cardFrameBits),
		.frameCount(cardFrames)
	);

	task automatic checkVal(input string name, input logic [127:0] actual,
		input logic [127:0] expected);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic loadStim();
		int fd;
		int got;
		string line;
		logic [31:0] fIndex;
		logic [31:0] fArgument;
		logic [31:0] fConfig;
		logic [31:0] fBehavior;
		logic [31:0] fBusy;
		logic [31:0] fStatus;
		logic [31:0] fCardErr;
		logic [119:0] fPayload;
		fd = $fopen("verification/sdCmd_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file");
			$display("TEST FAILED");
			$fatal(1, "no stimulus file");
		end
		while (!$feof(fd) && (stimCount < MAX_LINES)) begin
			got = $fgets(line, fd);
			if (got == 0)
				break;
			// Comment and blank lines do not scan as eight fields
			got = $sscanf(line, "%h %h %h %h %h %h %h %h", fIndex, fArgument, fConfig,
				fBehavior, fBusy, fPayload, fStatus, fCardErr);
			if (got == 8) begin
				stimIndex[stimCount] = fIndex[5:0];
				stimArgument[stimCount] = fArgument;
				stimConfig[stimCount] = fConfig[6:0];
				stimBehavior[stimCount] = fBehavior[3:0];
				stimBusy[stimCount] = fBusy[15:0];
				stimPayload[stimCount] = fPayload;
				stimStatus[stimCount] = fStatus[4:0];
				stimCardErr[stimCount] = fCardErr[0];
				stimCount++;
			end
		end
		$fclose(fd);
		if (stimCount == 0) begin
			$display("The stimulus file holds no commands");
			$display("TEST FAILED");
			$fatal(1, "empty stimulus");
		end
	endtask

	task automatic runCommand(input int n);
		int rxBefore;
		int txBefore;
		int expRx;
		int expTx;
		logic [5:0] expIndex;
		cmdConfigT cfg;
		cfg = cmdConfigT'(stimConfig[n]);
		rxBefore = rxPulses;
		txBefore = txPulses;
		@(posedge clk);
		cardBehavior <= stimBehavior[n];
		cardBusy <= stimBusy[n];
		cardKind <= cfg.respType;
		cardPayload <= stimPayload[n];
		reqValid <= 1'b1;
		reqIndex <= stimIndex[n];
		reqArgument <= stimArgument[n];
		reqConfig <= cfg;
		do @(posedge clk); while (!(reqValid && reqReady));
		reqValid <= 1'b0;
		do @(posedge clk); while (!(resValid && resReady));

		checkVal("resStatus", resStatus, stimStatus[n]);
		checkVal("resCardErr", resCardErr, stimCardErr[n]);
		if (stimBehavior[n] != SILENT) begin
			if (cfg.respType == RESP_SHORT) begin
				expIndex = (stimBehavior[n] == WRONG_INDEX) ? (stimIndex[n] ^ 6'h01) : stimIndex[n];
				checkVal("resResponse.index", resResponse.shortView.index, expIndex);
				checkVal("resResponse.cardStatus", resResponse.shortView.cardStatus,
					stimPayload[n][31:0]);
			end else if (cfg.respType == RESP_LONG) begin
				checkVal("resResponse", resResponse.longView, stimPayload[n]);
			end
		end

		// What the card saw on the CMD line
		checkVal("card frame count", cardFrames, n + 1);
		checkVal("card start/tx/stop bits", cardFrameBits, 3'b011);
		checkVal("card command index", cardIndex, stimIndex[n]);
		checkVal("card command argument", cardArgument, stimArgument[n]);
		checkVal("command CRC7", cardRxCrc, cardCalcCrc);

		// Data path kick only after a good finish
		expRx = (stimStatus[n][0] && (cfg.dataDir == DIR_READ)) ? 1 : 0;
		expTx = (stimStatus[n][0] && (cfg.dataDir == DIR_WRITE)) ? 1 : 0;
		checkVal("startRx pulses", rxPulses - rxBefore, expRx);
		checkVal("startTx pulses", txPulses - txBefore, expTx);
	endtask

	//////////////////////////////
	// Monitors
	//////////////////////////////

	// Random back-pressure on the result channel
	initial begin
		void'($urandom(63));
		forever begin
			@(posedge clk);
			resReady <= ($urandom % 2) == 0;
		end
	end

	always @(posedge clk) begin
		if (startRx)
			rxPulses <= rxPulses + 1;
		if (startTx)
			txPulses <= txPulses + 1;
	end

	always @(posedge clk) begin
		if (!rst) begin
			if (resValid)
				checkVal("reqReady while result pending", reqReady, 1'b0);
			if (sdBusy)
				checkVal("resValid while card busy", resValid, 1'b0);
			if (heldValid) begin
				checkVal("resValid under back-pressure", resValid, 1'b1);
				checkVal("held resStatus", resStatus, heldStatus);
				checkVal("held resResponse", resResponse, heldResponse);
				checkVal("held resCardErr", resCardErr, heldCardErr);
			end
		end
		heldValid <= resValid && !resReady && !rst;
		heldStatus <= resStatus;
		heldResponse <= resResponse;
		heldCardErr <= resCardErr;
	end

	initial begin
		wait (stimCount > 0);
		repeat (stimCount * CYCLES_PER_LINE + RESET_CYCLES) @(posedge clk);
		$display("Run timed out waiting for a result");
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		rst = 1'b1;
		reqValid = 1'b0;
		reqIndex = '0;
		reqArgument = '0;
		reqConfig = '0;
		timeoutValue = 16'd64;
		cardBehavior = '0;
		cardBusy = '0;
		cardKind = '0;
		cardPayload = '0;
		loadStim();
		repeat (RESET_CYCLES) @(posedge clk);
		checkVal("reqReady after reset", reqReady, 1'b1);
		checkVal("resValid after reset", resValid, 1'b0);
		checkVal("cmdOe after reset", cmdOe, 1'b0);
		checkVal("cmdOut after reset", cmdOut, 1'b1);
		checkVal("startRx after reset", startRx, 1'b0);
		checkVal("startTx after reset", startTx, 1'b0);
		rst <= 1'b0;
		for (int n = 0; n < stimCount; n++)
			runCommand(n);
		repeat (4) @(posedge clk);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/sdCardModel.sv */
`timescale 1ns/1ns
`default_nettype none

module sdCardModel (
	input  wire          clk,
	input  wire          cmdOut,
	input  wire          cmdOe,
	input  wire  [3:0]   behavior,
	input  wire  [15:0]  busyCycles,
	input  wire  [1:0]   respKind,
	input  wire  [119:0] payload,
	output logic         cmdIn,
	output logic         sdBusy,
	output logic [5:0]   rxIndex,
	output logic [31:0]  rxArgument,
	output logic [6:0]   rxCrc,
	output logic [6:0]   calcCrc,
	output logic [2:0]   rxFrameBits,
	output logic [15:0]  frameCount
);

	localparam logic [3:0] BAD_CRC = 4'd1;
	localparam logic [3:0] WRONG_INDEX = 4'd2;
	localparam logic [3:0] SILENT = 4'd3;
	localparam logic [3:0] BUSY = 4'd4;

	// One step of x^7 + x^3 + 1, data bit enters at the top
	function automatic logic [6:0] crc7Step(input logic [6:0] crc, input logic bitIn);
		logic fb;
		fb = bitIn ^ crc[6];
		crc7Step = {crc[5:0], 1'b0} ^ {3'b000, fb, 2'b00, fb};
	endfunction

	initial begin
		logic [47:0] frame;
		logic [126:0] respBits;
		logic [6:0] crc;
		logic [5:0] sendIndex;
		int respLen;
		int i;
		cmdIn = 1'b1;
		sdBusy = 1'b0;
		rxIndex = '0;
		rxArgument = '0;
		rxCrc = '0;
		calcCrc = '0;
		rxFrameBits = '0;
		frameCount = '0;
		forever begin
			@(posedge clk);
			if (cmdOe) begin
				// Start bit is the first driven bit
				frame[47] = cmdOut;
				for (i = 46; i >= 0; i--) begin
					@(posedge clk);
					frame[i] = cmdOut;
				end
				crc = '0;
				for (i = 47; i >= 8; i--)
					crc = crc7Step(crc, frame[i]);
				rxFrameBits = {frame[47], frame[46], frame[0]};
				rxIndex = frame[45:40];
				rxArgument = frame[39:8];
				rxCrc = frame[7:1];
				calcCrc = crc;
				frameCount = frameCount + 16'd1;
				if ((behavior != SILENT) && ((respKind == 2'b01) || (respKind == 2'b10))) begin
					sendIndex = (behavior == WRONG_INDEX) ? (rxIndex ^ 6'h01) : rxIndex;
					if (respKind == 2'b01) begin
						respLen = 39;
						respBits = {88'd0, 1'b0, sendIndex, payload[31:0]};
					end else begin
						// Transmission bit, reserved ones, then the CID/CSD body
						respLen = 127;
						respBits = {1'b0, 6'h3f, payload};
					end
					crc = '0;
					for (i = respLen - 1; i >= 0; i--)
						crc = crc7Step(crc, respBits[i]);
					if (behavior == BAD_CRC)
						crc = crc ^ 7'h01;
					// Turnaround
					repeat (8) @(posedge clk);
					cmdIn <= 1'b0;
					for (i = respLen - 1; i >= 0; i--) begin
						@(posedge clk);
						cmdIn <= respBits[i];
					end
					for (i = 6; i >= 0; i--) begin
						@(posedge clk);
						cmdIn <= crc[i];
					end
					@(posedge clk);
					cmdIn <= 1'b1;
					if (behavior == BUSY) begin
						sdBusy <= 1'b1;
						repeat (busyCycles) @(posedge clk);
						sdBusy <= 1'b0;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verification/tbClock.sv */
`timescale 1ns/1ns
`default_nettype none

module tbClock #(
	parameter int PERIOD = 8
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

/* hdl/sdCmdCtrl.sv */
`timescale 1ns/1ns
`default_nettype none
`include "sdCmd_settings.svh"

module sdCmdCtrl
	import sdHostPkg::*;
(
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      reqValid,
	input  wire  [5:0]               reqIndex,
	input  wire  [31:0]              reqArgument,
	input  wire  cmdConfigT          reqConfig,
	output logic                     reqReady,
	output logic                     resValid,
	output cmdStatusT                resStatus,
	output respWordT                 resResponse,
	output logic                     resCardErr,
	input  wire                      resReady,
	input  wire  [`CMD_TIMEOUT_W-1:0] timeoutValue,
	input  wire                      cmdIn,
	input  wire                      sdBusy,
	output logic                     cmdOut,
	output logic                     cmdOe,
	output logic                     startRx,
	output logic                     startTx
);

	// Front end to command path
	logic cmdStart;
	logic [5:0] cmdIndex;
	logic [31:0] cmdArgument;
	cmdConfigT cmdConfig;
	logic cmdDone;
	cmdStatusT cmdEvents;
	respWordT response;

	sdCmdFront front (
		.clk(clk),
		.rst(rst),
		.reqValid(reqValid),
		.reqIndex(reqIndex),
		.reqArgument(reqArgument),
		.reqConfig(reqConfig),
		.reqReady(reqReady),
		.resValid(resValid),
		.resStatus(resStatus),
		.resResponse(resResponse),
		.resCardErr(resCardErr),
		.resReady(resReady),
		.cmdStart(cmdStart),
		.cmdIndex(cmdIndex),
		.cmdArgument(cmdArgument),
		.cmdConfig(cmdConfig),
		.cmdDone(cmdDone),
		.cmdEvents(cmdEvents),
		.response(response)
	);

	sdCmdPath path (
		.clk(clk),
		.rst(rst),
		.cmdStart(cmdStart),
		.cmdIndex(cmdIndex),
		.cmdArgument(cmdArgument),
		.cmdConfig(cmdConfig),
		.timeoutValue(timeoutValue),
		.cmdIn(cmdIn),
		.sdBusy(sdBusy),
		.cmdDone(cmdDone),
		.cmdEvents(cmdEvents),
		.response(response),
		.cmdOut(cmdOut),
		.cmdOe(cmdOe),
		.startRx(startRx),
		.startTx(startTx)
	);

endmodule

`default_nettype wire

/* hdl/sdCmdFront.sv */
`timescale 1ns/1ns
`default_nettype none
`include "sdCmd_settings.svh"

module sdCmdFront
	import sdHostPkg::*;
(
	input  wire              clk,
	input  wire              rst,
	input  wire              reqValid,
	input  wire  [5:0]       reqIndex,
	input  wire  [31:0]      reqArgument,
	input  wire  cmdConfigT  reqConfig,
	output logic             reqReady,
	output logic             resValid,
	output cmdStatusT        resStatus,
	output respWordT         resResponse,
	output logic             resCardErr,
	input  wire              resReady,
	output logic             cmdStart,
	output logic [5:0]       cmdIndex,
	output logic [31:0]      cmdArgument,
	output cmdConfigT        cmdConfig,
	input  wire              cmdDone,
	input  wire  cmdStatusT  cmdEvents,
	input  wire  respWordT   response
);

	localparam logic [1:0] FRONT_IDLE = 2'd0;
	localparam logic [1:0] FRONT_BUSY = 2'd1;
	localparam logic [1:0] FRONT_PENDING = 2'd2;

	logic [1:0] frontState;
	logic accept;
	logic statusErr;

	assign reqReady = (frontState == FRONT_IDLE);
	assign resValid = (frontState == FRONT_PENDING);
	assign accept = reqValid && reqReady;
	assign statusErr = |(response.shortView.cardStatus & `CARD_STATUS_ERR_MASK);

	//////////////////////////////
	// Request and result holding
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			frontState <= FRONT_IDLE;
			cmdStart <= 1'b0;
		end else begin
			cmdStart <= accept;
			case (frontState)
				FRONT_IDLE: if (accept) frontState <= FRONT_BUSY;
				FRONT_BUSY: if (cmdDone) frontState <= FRONT_PENDING;
				// Held until the consumer takes it
				FRONT_PENDING: if (resReady) frontState <= FRONT_IDLE;
				default: frontState <= FRONT_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cmdIndex <= reqIndex;
			cmdArgument <= reqArgument;
			cmdConfig <= reqConfig;
		end
		if ((frontState == FRONT_BUSY) && cmdDone) begin
			resStatus <= cmdEvents;
			resResponse <= response;
			// Card status only means something in a good short response
			resCardErr <= cmdEvents.ok && (cmdConfig.respType == RESP_SHORT) && statusErr;
		end
	end

	resultHeld: assert property (@(posedge clk) disable iff (rst)
		(resValid && !resReady) |=> (resValid && $stable(resStatus)
		&& $stable(resResponse) && $stable(resCardErr)));

endmodule

`default_nettype wire

/* hdl/sdCmdPath.sv */
`timescale 1ns/1ns
`default_nettype none
`include "sdCmd_settings.svh"

module sdCmdPath
	import sdHostPkg::*, sdLinePkg::*;
(
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      cmdStart,
	input  wire  [5:0]               cmdIndex,
	input  wire  [31:0]              cmdArgument,
	input  wire  cmdConfigT          cmdConfig,
	input  wire  [`CMD_TIMEOUT_W-1:0] timeoutValue,
	input  wire                      cmdIn,
	input  wire                      sdBusy,
	output logic                     cmdDone,
	output cmdStatusT                cmdEvents,
	output respWordT                 response,
	output logic                     cmdOut,
	output logic                     cmdOe,
	output logic                     startRx,
	output logic                     startTx
);

	cmdStateT state;
	cmdStateT nextState;
	logic cmdInReg;
	logic [7:0] bitCounter;
	logic [7:0] respLen;
	logic [TX_FRAME_BITS-1:0] txShift;
	respWordT rxShift;
	logic [`CMD_TIMEOUT_W-1:0] timeoutCounter;
	logic inWait;
	logic expectResp;
	logic indexErr;
	logic crcErr;
	logic cmdTimeout;
	logic errorEvent;
	logic crcEn;
	logic crcClr;
	logic crcDin;
	logic crcBit;

	assign expectResp = (cmdConfig.respType == RESP_SHORT) || (cmdConfig.respType == RESP_LONG);
	assign respLen = (cmdConfig.respType == RESP_SHORT) ? 8'(`SHORT_RESP_BITS) :
		8'(`LONG_RESP_BITS);
	assign inWait = (state == waitResp) || (state == waitBusy);

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	always_comb begin
		nextState = state;
		case (state)
			idle: if (cmdStart) nextState = txData;
			txData: if (bitCounter == TX_FRAME_BITS - 8'd1) nextState = txCrc;
			txCrc: if (bitCounter == TX_CRC_END - 8'd1) nextState = txStop;
			txStop: nextState = txClear;
			txClear: begin
				// Give the line back to the card before listening
				if (bitCounter == TURNAROUND_END - 8'd1) begin
					if (expectResp)
						nextState = waitResp;
					else if (cmdConfig.checkBusy)
						nextState = waitBusy;
					else
						nextState = cmdFin;
				end
			end
			waitResp: begin
				if (cmdTimeout)
					nextState = idle;
				else if (!cmdInReg)
					nextState = rxData;
			end
			rxData: if (bitCounter == respLen) nextState = rxCrc;
			rxCrc: if (bitCounter == respLen + 8'd7) nextState = rxStop;
			rxStop: begin
				if (indexErr || crcErr)
					nextState = idle;
				else if (cmdConfig.checkBusy)
					nextState = waitBusy;
				else
					nextState = cmdFin;
			end
			waitBusy: begin
				if (cmdTimeout)
					nextState = idle;
				else if (!sdBusy)
					nextState = cmdFin;
			end
			default: nextState = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			cmdDone <= 1'b0;
			cmdInReg <= 1'b1;
			bitCounter <= '0;
			cmdOut <= 1'b1;
			cmdOe <= 1'b0;
			startRx <= 1'b0;
			startTx <= 1'b0;
		end else begin
			state <= nextState;
			cmdDone <= (state != idle) && (nextState == idle);
			cmdInReg <= cmdIn;
			if (state inside {txData, txCrc, txStop, txClear, rxData, rxCrc, rxStop})
				bitCounter <= bitCounter + 8'd1;
			else
				bitCounter <= '0;
			case (state)
				txData: cmdOut <= txShift[TX_FRAME_BITS-1];
				txCrc: cmdOut <= crcBit;
				default: cmdOut <= 1'b1;
			endcase
			cmdOe <= state inside {txData, txCrc, txStop};
			// Hand off to the data path only after a clean finish
			startRx <= (state == cmdFin) && (cmdConfig.dataDir == DIR_READ);
			startTx <= (state == cmdFin) && (cmdConfig.dataDir == DIR_WRITE);
		end
	end

	//////////////////////////////
	// Shifters and CRC
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (cmdStart)
			txShift <= {2'b01, cmdIndex, cmdArgument};
		else if (state == txData)
			txShift <= {txShift[TX_FRAME_BITS-2:0], 1'b1};
		if (state == rxData)
			rxShift.longView <= {rxShift.longView[118:0], cmdInReg};
	end

	assign crcEn = (state == txData) || (state == rxData);
	// Start bit is a zero and leaves a cleared CRC untouched
	assign crcClr = (state == idle) || (state == waitResp);
	assign crcDin = (state == txData) ? txShift[TX_FRAME_BITS-1] : cmdInReg;

	sdCrc7 crc (
		.clk(clk),
		.rst(rst),
		.crcEn(crcEn),
		.crcClr(crcClr),
		.crcDin(crcDin),
		.crcBit(crcBit)
	);

	//////////////////////////////
	// Checks and timeout
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (rst || !inWait)
			timeoutCounter <= '0;
		else if (timeoutCounter != timeoutValue)
			timeoutCounter <= timeoutCounter + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst || cmdStart) begin
			indexErr <= 1'b0;
			crcErr <= 1'b0;
			cmdTimeout <= 1'b0;
		end else begin
			if ((state == rxCrc) && cmdConfig.checkCrc && (crcBit != cmdInReg))
				crcErr <= 1'b1;
			// Short payload is complete once the CRC field starts
			if ((state == rxCrc) && cmdConfig.checkIndex && (cmdConfig.respType == RESP_SHORT)
				&& (rxShift.shortView.index != cmdIndex))
				indexErr <= 1'b1;
			// A start bit or busy release in the same cycle wins
			if (inWait && (nextState == state) && (timeoutValue != '0)
				&& (timeoutCounter == timeoutValue))
				cmdTimeout <= 1'b1;
		end
	end

	assign errorEvent = indexErr || crcErr || cmdTimeout;
	assign cmdEvents = '{
		indexErr: indexErr,
		crcErr: crcErr,
		timeout: cmdTimeout,
		error: errorEvent,
		ok: !errorEvent
	};
	assign response = rxShift;

	lineReleased: assert property (@(posedge clk) disable iff (rst)
		(state inside {waitResp, rxData}) |-> !cmdOe);

	startWhenIdle: assert property (@(posedge clk) disable iff (rst)
		cmdStart |-> (state == idle));

endmodule

`default_nettype wire

/* hdl/sdCrc7.sv */
`timescale 1ns/1ns
`default_nettype none

module sdCrc7 (
	input  wire  clk,
	input  wire  rst,
	input  wire  crcEn,
	input  wire  crcClr,
	input  wire  crcDin,
	output logic crcBit
);

	logic [6:0] crcReg;
	logic feedback;

	// x^7 + x^3 + 1
	assign feedback = crcDin ^ crcReg[6];
	assign crcBit = crcReg[6];

	always_ff @(posedge clk) begin
		if (rst || crcClr) begin
			crcReg <= '0;
		end else if (crcEn) begin
			crcReg <= {crcReg[5:3], crcReg[2] ^ feedback, crcReg[1:0], feedback};
		end else begin
			// Remainder goes out MSB first
			crcReg <= {crcReg[5:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

/* hdl/sdLinePkg.sv */
`default_nettype none

package sdLinePkg;

	// Command path sequence on the CMD line
	typedef enum logic [3:0] {
		idle = 4'h0,
		txData = 4'h1,
		txCrc = 4'h2,
		txStop = 4'h3,
		txClear = 4'h4,
		waitResp = 4'h5,
		rxData = 4'h6,
		rxCrc = 4'h7,
		rxStop = 4'h8,
		waitBusy = 4'h9,
		cmdFin = 4'ha
	} cmdStateT;

	// Bit counts within the command frame
	// start, transmission, index and argument bits
	localparam logic [7:0] TX_FRAME_BITS = 8'd40;
	// End of the CRC7 field
	localparam logic [7:0] TX_CRC_END = 8'd47;
	// Line released back to the card
	localparam logic [7:0] TURNAROUND_END = 8'd51;

endpackage

`default_nettype wire

/* hdl/sdHostPkg.sv */
`default_nettype none

package sdHostPkg;

	// dataDir encodings
	localparam logic [1:0] DIR_READ = 2'b01;
	localparam logic [1:0] DIR_WRITE = 2'b10;

	// respType encodings, 2'b00 is no response and 2'b11 is no response with busy
	localparam logic [1:0] RESP_SHORT = 2'b01;
	localparam logic [1:0] RESP_LONG = 2'b10;

	typedef struct packed {
		logic [1:0] dataDir;
		logic checkIndex;
		logic checkCrc;
		logic checkBusy;
		logic [1:0] respType;
	} cmdConfigT;

	typedef struct packed {
		logic indexErr;
		logic crcErr;
		logic timeout;
		logic error;
		logic ok;
	} cmdStatusT;

	// Received response word, short R1/R3/R6 layout or long CID/CSD body
	typedef union packed {
		struct packed {
			logic [80:0] filler;
			logic txBit;
			logic [5:0] index;
			logic [31:0] cardStatus;
		} shortView;
		logic [119:0] longView;
	} respWordT;

endpackage

`default_nettype wire

/* hdl/sdCmd_settings.svh */
`ifndef SD_CMD_SETTINGS_SVH
`define SD_CMD_SETTINGS_SVH

// Width of the response and busy timeout counter
`define CMD_TIMEOUT_W 16

// Bit count of the last payload bit, counted from the transmission bit
`define SHORT_RESP_BITS 38
`define LONG_RESP_BITS 126

// R1 card status bits that flag an error
// out of range, address, block length, erase, WP, lock, COM CRC, illegal,
// ECC, CC, generic error, CSD overwrite, erase skip, AKE sequence
`define CARD_STATUS_ERR_MASK 32'hFDFF_E008

`endif
